/* design/mult_operand_prep.sv */
// multiplier operand preparation

`timescale 1ns/1ps

module mult_operand_prep #(
	parameter int num_stage = mult_pkg::default_num_stage
) (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  mult_pkg::mult_func_t func,
	input  logic [mult_pkg::xlen-1:0] mcand,
	input  logic [mult_pkg::xlen-1:0] mplier,
	input  mult_pkg::tag_t dest_tag_in,

	output mult_pkg::dword_t mcand_ext,
	output mult_pkg::dword_t mplier_ext,
	output logic valid,
	output mult_pkg::tag_t tag,
	output logic take_high
);

	mult_pkg::sign_mode_t sign_mode;
	mult_pkg::dword_t mcand_next;
	mult_pkg::dword_t mplier_next;
	logic mcand_signed;
	logic mplier_signed;
	logic take_high_next;

	// the stage slices have to tile the full 64-bit multiplier
	if ((num_stage != 2) && (num_stage != 4) && (num_stage != 8)) begin : g_bad_depth
		$error("mult_operand_prep: num_stage %0d must be 2, 4 or 8", num_stage);
	end

	////////////////////
	// function decode

	always_comb begin
		case (func)
			mult_pkg::mul:    sign_mode = mult_pkg::sign_both;
			mult_pkg::mulh:   sign_mode = mult_pkg::sign_both;
			mult_pkg::mulhsu: sign_mode = mult_pkg::sign_mcand;  // rs2 unsigned
			mult_pkg::mulhu:  sign_mode = mult_pkg::sign_none;
			default:          sign_mode = mult_pkg::sign_both;
		endcase
	end

	assign mcand_signed = sign_mode[0];
	assign mplier_signed = sign_mode[1];
	assign take_high_next = (func != mult_pkg::mul);  // every func but mul wants the top word

	////////////////////
	// extension to 64 bits

	// upper half is either copies of the sign bit or zero
	always_comb begin
		mcand_next.halves[mult_pkg::lo_half] = mcand;
		mcand_next.halves[mult_pkg::hi_half] =
			{mult_pkg::xlen{mcand_signed & mcand[mult_pkg::xlen-1]}};
		mplier_next.halves[mult_pkg::lo_half] = mplier;
		mplier_next.halves[mult_pkg::hi_half] =
			{mult_pkg::xlen{mplier_signed & mplier[mult_pkg::xlen-1]}};
	end

	////////////////////
	// launch register

	always_ff @(posedge clock) begin
		mcand_ext <= mcand_next;
		mplier_ext <= mplier_next;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= 1'b0;
			tag <= '0;
			take_high <= 1'b0;
		end else begin
			valid <= start;
			tag <= dest_tag_in;
			take_high <= take_high_next;
		end
	end

endmodule

/* design/mult_pkg.sv */
// RV32 M multiplier
// shared widths and types

package mult_pkg;

	////////////////////
	// widths

	localparam int xlen = 32;         // operand and result width
	localparam int dword = 2 * xlen;  // full product width
	localparam int tag_bits = 6;      // physical register tag

	// pipeline depth when the top level is left alone
	localparam int default_num_stage = 4;

	// half positions inside a double word
	localparam int lo_half = 0;
	localparam int hi_half = 1;

	////////////////////
	// types

	// destination physical register
	typedef logic [tag_bits-1:0] tag_t;

	// funct3[1:0] of the M extension multiply group
	typedef enum logic [1:0] {
		mul    = 2'b00,  // low word, signed x signed
		mulh   = 2'b01,  // high word, signed x signed
		mulhsu = 2'b10,  // high word, signed x unsigned
		mulhu  = 2'b11   // high word, unsigned x unsigned
	} mult_func_t;

	// bit 0 set when the multiplicand is signed
	// bit 1 set when the multiplier is signed
	typedef enum logic [1:0] {
		sign_none  = 2'b00,
		sign_mcand = 2'b01,
		sign_both  = 2'b11
	} sign_mode_t;

	// double width word, read whole for the adder chain
	// or split into halves for extension and result select
	typedef union packed {
		logic [dword-1:0] whole;
		logic [1:0][xlen-1:0] halves;
	} dword_t;

endpackage

/* design/mult_product_select.sv */
// multiplier result select

`timescale 1ns/1ps

module mult_product_select (
	input  logic clock,
	input  logic reset,
	input  logic valid_in,
	input  mult_pkg::dword_t sum_in,
	input  mult_pkg::tag_t tag_in,
	input  logic take_high_in,

	output logic done,
	output logic [mult_pkg::xlen-1:0] product,
	output mult_pkg::tag_t dest_tag_out
);

	logic [mult_pkg::xlen-1:0] product_next;

	// mulh, mulhsu, mulhu read the top word, mul the bottom one
	assign product_next = take_high_in ? sum_in.halves[mult_pkg::hi_half]
	                                   : sum_in.halves[mult_pkg::lo_half];

	////////////////////
	// result register

	always_ff @(posedge clock) begin
		product <= product_next;  // qualified by done
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
			dest_tag_out <= '0;
		end else begin
			done <= valid_in;
			dest_tag_out <= tag_in;
		end
	end

endmodule

/* design/mult_stage.sv */
// multiplier partial product stage

`timescale 1ns/1ps

module mult_stage #(
	parameter int num_stage = mult_pkg::default_num_stage
) (
	input  logic clock,
	input  logic reset,
	input  logic valid_in,
	input  mult_pkg::dword_t mcand_in,
	input  mult_pkg::dword_t mplier_in,
	input  mult_pkg::dword_t sum_in,
	input  mult_pkg::tag_t tag_in,
	input  logic take_high_in,

	output logic valid_out,
	output mult_pkg::dword_t mcand_out,
	output mult_pkg::dword_t mplier_out,
	output mult_pkg::dword_t sum_out,
	output mult_pkg::tag_t tag_out,
	output logic take_high_out
);

	// multiplier bits consumed per stage
	localparam int slice_bits = mult_pkg::dword / num_stage;

	logic [slice_bits-1:0] mplier_slice;
	logic [mult_pkg::dword-1:0] partial_prod;
	logic [mult_pkg::dword-1:0] sum_next;
	logic [mult_pkg::dword-1:0] mplier_next;
	logic [mult_pkg::dword-1:0] mcand_next;

	assign mplier_slice = mplier_in.whole[slice_bits-1:0];

	// slice times the shifted multiplicand, truncated to 64 bits
	// sign extension already done, so mod 2^64 arithmetic is exact
	assign partial_prod =
		{{(mult_pkg::dword-slice_bits){1'b0}}, mplier_slice} * mcand_in.whole;

	assign sum_next = sum_in.whole + partial_prod;

	// move the next slice down and line the multiplicand up with it
	assign mplier_next = mplier_in.whole >> slice_bits;
	assign mcand_next = mcand_in.whole << slice_bits;

	////////////////////
	// stage registers

	always_ff @(posedge clock) begin
		sum_out.whole <= sum_next;
		mplier_out.whole <= mplier_next;
		mcand_out.whole <= mcand_next;
	end

	// control travels alongside the data
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_out <= 1'b0;
			tag_out <= '0;
			take_high_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
			tag_out <= tag_in;
			take_high_out <= take_high_in;
		end
	end

endmodule

/* design/pipelined_mult.sv */
// pipelined RV32 M multiplier
// prep, num_stage partial product stages, result select

`timescale 1ns/1ps

module pipelined_mult #(
	parameter int num_stage = mult_pkg::default_num_stage
) (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  mult_pkg::mult_func_t func,
	input  logic [mult_pkg::xlen-1:0] mcand,
	input  logic [mult_pkg::xlen-1:0] mplier,
	input  mult_pkg::tag_t dest_tag_in,

	output logic done,
	output logic [mult_pkg::xlen-1:0] product,
	output mult_pkg::tag_t dest_tag_out
);

	// index i feeds stage i, index num_stage feeds the select
	mult_pkg::dword_t mcand_chain [num_stage+1];
	mult_pkg::dword_t mplier_chain [num_stage+1];
	mult_pkg::dword_t sum_chain [num_stage+1];
	mult_pkg::tag_t tag_chain [num_stage+1];
	logic valid_chain [num_stage+1];
	logic take_high_chain [num_stage+1];

	assign sum_chain[0] = '0;  // accumulation starts empty

	////////////////////
	// operand prep

	mult_operand_prep #(
		.num_stage(num_stage)
	) prep0 (
		.clock(clock),
		.reset(reset),
		.start(start),
		.func(func),
		.mcand(mcand),
		.mplier(mplier),
		.dest_tag_in(dest_tag_in),
		.mcand_ext(mcand_chain[0]),
		.mplier_ext(mplier_chain[0]),
		.valid(valid_chain[0]),
		.tag(tag_chain[0]),
		.take_high(take_high_chain[0])
	);

	////////////////////
	// stage chain

	for (genvar i = 0; i < num_stage; i++) begin : g_stage
		mult_stage #(
			.num_stage(num_stage)
		) stage (
			.clock(clock),
			.reset(reset),
			.valid_in(valid_chain[i]),
			.mcand_in(mcand_chain[i]),
			.mplier_in(mplier_chain[i]),
			.sum_in(sum_chain[i]),
			.tag_in(tag_chain[i]),
			.take_high_in(take_high_chain[i]),
			.valid_out(valid_chain[i+1]),
			.mcand_out(mcand_chain[i+1]),
			.mplier_out(mplier_chain[i+1]),
			.sum_out(sum_chain[i+1]),
			.tag_out(tag_chain[i+1]),
			.take_high_out(take_high_chain[i+1])
		);
	end

	////////////////////
	// result select

	mult_product_select select0 (
		.clock(clock),
		.reset(reset),
		.valid_in(valid_chain[num_stage]),
		.sum_in(sum_chain[num_stage]),
		.tag_in(tag_chain[num_stage]),
		.take_high_in(take_high_chain[num_stage]),
		.done(done),
		.product(product),
		.dest_tag_out(dest_tag_out)
	);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pipelined multiplier testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
	-f sim.f \
	--top-module pipelined_mult_tb \
	-Mdir "$build_dir" \
	-o sim_pipelined_mult

"./$build_dir/sim_pipelined_mult" | tee "$log_file"

if grep -q "CHECKS FAILED" "$log_file"; then
	echo "simulation reported failures, see $log_file"
	exit 1
fi

echo "simulation finished without failures"

/* sim.f */
design/mult_pkg.sv
design/mult_operand_prep.sv
design/mult_stage.sv
design/mult_product_select.sv
design/pipelined_mult.sv
verification/pipelined_mult_properties.sv
verification/pipelined_mult_tb.sv

/* verification/pipelined_mult_properties.sv */
// multiplier timing assertions

`timescale 1ns/1ps

module pipelined_mult_properties #(
	parameter int num_stage = mult_pkg::default_num_stage
) (
	input logic clock,
	input logic reset,
	input logic start,
	input mult_pkg::tag_t dest_tag_in,
	input logic done,
	input mult_pkg::tag_t dest_tag_out
);

	localparam int latency = num_stage + 2;  // prep, stages, select

	// sync reset clears done after one edge
	done_low_in_reset: assert property (
		@(posedge clock) (reset && $past(reset)) |-> !done
	) else $error("done is high while reset is held");

	// one done per start, and none without
	done_latency: assert property (
		@(posedge clock) disable iff (reset) done == $past(start, latency)
	) else $error("done is not %0d cycles after start", latency);

	done_tag: assert property (
		@(posedge clock) disable iff (reset)
			done |-> (dest_tag_out == $past(dest_tag_in, latency))
	) else $error("dest_tag_out differs from the tag given at start");

endmodule

bind pipelined_mult pipelined_mult_properties #(
	.num_stage(num_stage)
) props0 (
	.clock(clock),
	.reset(reset),
	.start(start),
	.dest_tag_in(dest_tag_in),
	.done(done),
	.dest_tag_out(dest_tag_out)
);

/* verification/pipelined_mult_tb.sv */
// pipelined multiplier testbench

`timescale 1ns/1ps

module pipelined_mult_tb;

	localparam int xlen = mult_pkg::xlen;
	localparam int num_stage = mult_pkg::default_num_stage;
	localparam int latency = num_stage + 2;  // prep + stages + select
	localparam int reset_cycles = 10;
	localparam int num_directed = 18;
	localparam int num_random = 32;
	localparam int num_entries = num_directed + num_random;
	localparam int cycle_limit = reset_cycles + num_entries + latency + 20;

	logic clock;
	logic reset;
	logic start;
	mult_pkg::mult_func_t func;
	logic [xlen-1:0] mcand;
	logic [xlen-1:0] mplier;
	mult_pkg::tag_t dest_tag_in;
	logic done;
	logic [xlen-1:0] product;
	mult_pkg::tag_t dest_tag_out;

	////////////////////
	// stimulus table

	string name_tbl [num_entries];
	mult_pkg::mult_func_t func_tbl [num_entries];
	logic [xlen-1:0] mcand_tbl [num_entries];
	logic [xlen-1:0] mplier_tbl [num_entries];
	mult_pkg::tag_t tag_tbl [num_entries];
	logic start_tbl [num_entries];

	// expected results, oldest first
	string exp_name_q [$];
	logic [xlen-1:0] exp_product_q [$];
	mult_pkg::tag_t exp_tag_q [$];
	int exp_cycle_q [$];

	int cycle;
	int mismatch_count;
	int other_count;
	integer seed;

	pipelined_mult dut0 (
		.clock(clock),
		.reset(reset),
		.start(start),
		.func(func),
		.mcand(mcand),
		.mplier(mplier),
		.dest_tag_in(dest_tag_in),
		.done(done),
		.product(product),
		.dest_tag_out(dest_tag_out)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle = cycle + 1;
		if (cycle > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	////////////////////
	// reference model

	function automatic logic [xlen-1:0] ref_result(input mult_pkg::mult_func_t f,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		logic [2*xlen-1:0] a_ext;
		logic [2*xlen-1:0] b_ext;
		logic [2*xlen-1:0] full;
		// multiplicand unsigned only for mulhu
		a_ext = (f == mult_pkg::mulhu) ? {{xlen{1'b0}}, a} : {{xlen{a[xlen-1]}}, a};
		// multiplier signed only for mul and mulh
		if (f == mult_pkg::mul || f == mult_pkg::mulh)
			b_ext = {{xlen{b[xlen-1]}}, b};
		else
			b_ext = {{xlen{1'b0}}, b};
		full = a_ext * b_ext;
		return (f == mult_pkg::mul) ? full[xlen-1:0] : full[2*xlen-1:xlen];
	endfunction

	task automatic set_entry(input int idx, input string name, input mult_pkg::mult_func_t f,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b, input mult_pkg::tag_t t,
			input logic s);
		name_tbl[idx] = name;
		func_tbl[idx] = f;
		mcand_tbl[idx] = a;
		mplier_tbl[idx] = b;
		tag_tbl[idx] = t;
		start_tbl[idx] = s;
	endtask

	task automatic fill_directed();
		set_entry(0, "mul_small", mult_pkg::mul, 32'd7, 32'd6, 6'd1, 1'b1);
		set_entry(1, "mul_neg_pos", mult_pkg::mul, 32'hfffffffd, 32'd5, 6'd2, 1'b1);
		set_entry(2, "mul_min_by_neg1", mult_pkg::mul, 32'h80000000, 32'hffffffff, 6'd3, 1'b1);
		set_entry(3, "mul_neg_neg", mult_pkg::mul, 32'hfffffff9, 32'hfffffff7, 6'd4, 1'b1);
		set_entry(4, "idle_a", mult_pkg::mul, 32'd0, 32'd0, 6'd0, 1'b0);
		set_entry(5, "mulh_pos", mult_pkg::mulh, 32'h40000000, 32'd4, 6'd5, 1'b1);
		set_entry(6, "mulh_min_sq", mult_pkg::mulh, 32'h80000000, 32'h80000000, 6'd6, 1'b1);
		set_entry(7, "mulh_neg_pos", mult_pkg::mulh, 32'hffffffff, 32'h7fffffff, 6'd7, 1'b1);
		set_entry(8, "mulhsu_neg1", mult_pkg::mulhsu, 32'hffffffff, 32'hffffffff, 6'd8, 1'b1);
		set_entry(9, "mulhsu_mix", mult_pkg::mulhsu, 32'h12345678, 32'h9abcdef0, 6'd9, 1'b1);
		set_entry(10, "mulhu_ones", mult_pkg::mulhu, 32'hffffffff, 32'hffffffff, 6'd10, 1'b1);
		set_entry(11, "mulhu_half", mult_pkg::mulhu, 32'h80000000, 32'd2, 6'd11, 1'b1);
		set_entry(12, "idle_b", mult_pkg::mul, 32'd0, 32'd0, 6'd0, 1'b0);
		set_entry(13, "idle_c", mult_pkg::mul, 32'd0, 32'd0, 6'd0, 1'b0);
		// back to back, one function each
		set_entry(14, "b2b_mul", mult_pkg::mul, 32'hdeadbeef, 32'h01234567, 6'd12, 1'b1);
		set_entry(15, "b2b_mulh", mult_pkg::mulh, 32'hdeadbeef, 32'h01234567, 6'd13, 1'b1);
		set_entry(16, "b2b_mulhsu", mult_pkg::mulhsu, 32'hdeadbeef, 32'h89abcdef, 6'd14, 1'b1);
		set_entry(17, "b2b_mulhu", mult_pkg::mulhu, 32'hdeadbeef, 32'h89abcdef, 6'd15, 1'b1);
	endtask

	task automatic fill_random();
		logic [31:0] rnd;
		for (int i = num_directed; i < num_entries; i++) begin
			rnd = $random(seed);
			func_tbl[i] = mult_pkg::mult_func_t'(rnd[1:0]);
			start_tbl[i] = (rnd[4:2] != 3'b000);  // mostly busy, some idle slots
			mcand_tbl[i] = $random(seed);
			mplier_tbl[i] = $random(seed);
			tag_tbl[i] = 6'(i);  // distinct from the directed tags
			name_tbl[i] = $sformatf("rand_%0d", i - num_directed);
		end
	endtask

	task automatic apply_entry(input int idx);
		start = start_tbl[idx];
		func = func_tbl[idx];
		mcand = mcand_tbl[idx];
		mplier = mplier_tbl[idx];
		dest_tag_in = tag_tbl[idx];
		if (start_tbl[idx]) begin
			exp_name_q.push_back(name_tbl[idx]);
			exp_product_q.push_back(ref_result(func_tbl[idx], mcand_tbl[idx], mplier_tbl[idx]));
			exp_tag_q.push_back(tag_tbl[idx]);
			exp_cycle_q.push_back(cycle);
		end
	endtask

	////////////////////
	// compare tasks

	task automatic check_product(input string name, input logic [xlen-1:0] expected,
			input logic [xlen-1:0] actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s product expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_tag(input string name, input mult_pkg::tag_t expected,
			input mult_pkg::tag_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s tag expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_latency(input string name, input int start_cycle, input int done_cycle);
		if (done_cycle - start_cycle != latency) begin
			other_count++;
			$display("%s finished %0d cycles after its start instead of %0d",
				name, done_cycle - start_cycle, latency);
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clock) begin
		string name;
		int start_cycle;
		if (reset) begin
			if (cycle >= 1 && done !== 1'b0) begin
				other_count++;
				$display("done is not low during reset at cycle %0d", cycle);
			end
		end else if (done === 1'b1) begin
			if (exp_product_q.size() == 0) begin
				other_count++;
				$display("done at cycle %0d with no operation in flight", cycle);
			end else begin
				name = exp_name_q.pop_front();
				start_cycle = exp_cycle_q.pop_front();
				check_product(name, exp_product_q.pop_front(), product);
				check_tag(name, exp_tag_q.pop_front(), dest_tag_out);
				check_latency(name, start_cycle, cycle);
			end
		end else if (done !== 1'b0) begin
			other_count++;
			$display("done is unknown at cycle %0d", cycle);
		end
	end

	initial begin
		seed = 32'h6687;
		cycle = 0;
		mismatch_count = 0;
		other_count = 0;
		reset = 1'b1;
		start = 1'b0;
		func = mult_pkg::mul;
		mcand = '0;
		mplier = '0;
		dest_tag_in = '0;
		clock = 1'b0;
		fill_directed();
		fill_random();
		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < num_entries; i++) begin
			apply_entry(i);
			@(negedge clock);
		end
		start = 1'b0;
		// drain, then watch a few idle cycles for stray done pulses
		while (exp_product_q.size() != 0) @(negedge clock);
		repeat (4) @(negedge clock);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
